// File: ascon_hash.f
+incdir+.
ascon_const_pkg.sv
ascon_ctrl_pkg.sv
ascon_ctl_if.sv
ascon_pad_stage.sv
ascon_round.sv
ascon_state.sv
ascon_hash_fsm.sv
ascon_hash_top.sv
tb_ascon_hash.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ascon_hash \
	  -f ascon_hash.f -o tb_ascon_hash
	./obj_dir/tb_ascon_hash | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_ascon_model.svh
`ifndef TB_ASCON_MODEL_SVH
`define TB_ASCON_MODEL_SVH

  // Ascon 5-bit S-box, x0 is the MSB of both index and value
  localparam logic [4:0] SBOX_TABLE [32] = '{
    5'h04, 5'h0b, 5'h1f, 5'h14, 5'h1a, 5'h15, 5'h09, 5'h02,
    5'h1b, 5'h05, 5'h08, 5'h12, 5'h1d, 5'h03, 5'h06, 5'h1c,
    5'h1e, 5'h13, 5'h07, 5'h0e, 5'h00, 5'h0d, 5'h11, 5'h18,
    5'h10, 5'h0c, 5'h01, 5'h19, 5'h16, 5'h0a, 5'h0f, 5'h17
  };

  function automatic word_t rot_right(word_t x, int n);
    logic [2*WORD_W-1:0] both;
    both = {x, x} >> n;
    return both[WORD_W-1:0];
  endfunction

  // One round of Ascon-p, S-box applied per bit column
  function automatic state_t apply_round(state_t s, round_idx_t r);
    state_t     t;
    logic [4:0] col;
    // Round constant is (15 - r) in the high nibble, r in the low one
    s[2] = s[2] ^ word_t'({4'(4'hf - r), r});
    for (int b = 0; b < WORD_W; b++) begin
      col = SBOX_TABLE[{s[0][b], s[1][b], s[2][b], s[3][b], s[4][b]}];
      for (int l = 0; l < LANES; l++) t[l][b] = col[LANES-1-l];
    end
    t[0] = t[0] ^ rot_right(t[0], 19) ^ rot_right(t[0], 28);
    t[1] = t[1] ^ rot_right(t[1], 61) ^ rot_right(t[1], 39);
    t[2] = t[2] ^ rot_right(t[2], 1) ^ rot_right(t[2], 6);
    t[3] = t[3] ^ rot_right(t[3], 10) ^ rot_right(t[3], 17);
    t[4] = t[4] ^ rot_right(t[4], 7) ^ rot_right(t[4], 41);
    return t;
  endfunction

  function automatic state_t apply_perm(state_t s);
    for (int r = 0; r < ROUNDS_A; r++) s = apply_round(s, round_idx_t'(r));
    return s;
  endfunction

  // Digest words in bus order, each one byte-swapped from x0
  function automatic void expected_digest(input logic [7:0] msg [$],
                                          output word_t dig [HASH_WORDS]);
    state_t s;
    word_t  blk;
    int     pos;
    s    = '0;
    s[0] = IV_HASH;
    s    = apply_perm(s);
    // One block more than the full words, the last one holds the 0x01
    for (int i = 0; i <= msg.size() / BYTES_W; i++) begin
      blk = '0;
      for (int j = 0; j < BYTES_W; j++) begin
        pos = i * BYTES_W + j;
        if (pos < msg.size()) blk[j*8 +: 8] = msg[pos];
        else if (pos == msg.size()) blk[j*8 +: 8] = 8'h01;
      end
      s[0] = s[0] ^ blk;
      s    = apply_perm(s);
    end
    for (int k = 0; k < HASH_WORDS; k++) begin
      if (k > 0) s = apply_perm(s);
      dig[k] = {<<8{s[0]}};
    end
  endfunction

`endif

// File: tb_ascon_hash.sv
`timescale 1ns/1ps

module tb_ascon_hash;
  import ascon_const_pkg::*;
  import ascon_ctrl_pkg::*;

  localparam int TIMEOUT = 500;

  logic  clk;
  logic  rst;
  logic  start_i;
  logic  eoi_i;
  word_t bdi_i;
  strb_t bdi_valid_i;
  logic  bdi_eot_i;
  logic  bdo_ready_i;
  logic  bdi_ready_o;
  word_t bdo_o;
  logic  bdo_valid_o;
  logic  bdo_eot_o;
  logic  done_o;

  // Chance in percent of an input gap or an output stall per cycle
  int    gap_pct;
  int    stall_pct;

  `include "tb_ascon_model.svh"

  ascon_hash_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .eoi_i       (eoi_i),
    .bdi_i       (bdi_i),
    .bdi_valid_i (bdi_valid_i),
    .bdi_eot_i   (bdi_eot_i),
    .bdo_ready_i (bdo_ready_i),
    .bdi_ready_o (bdi_ready_o),
    .bdo_o       (bdo_o),
    .bdo_valid_o (bdo_valid_o),
    .bdo_eot_o   (bdo_eot_o),
    .done_o      (done_o)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      fail_now($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      fail_now($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_idle(string name);
    check_bit({name, " bdi_ready_o"}, 1'b0, bdi_ready_o);
    check_bit({name, " bdo_valid_o"}, 1'b0, bdo_valid_o);
    check_bit({name, " bdo_eot_o"}, 1'b0, bdo_eot_o);
    check_bit({name, " done_o"}, 1'b0, done_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Caller has rst high for the next edge, two edges in total
  task automatic finish_reset();
    @(posedge clk);
    @(negedge clk);
    check_idle("in reset");
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle("after reset");
  endtask

  task automatic start_message(logic empty);
    @(posedge clk);
    start_i <= 1'b1;
    eoi_i   <= empty;
    @(posedge clk);
    start_i <= 1'b0;
    eoi_i   <= 1'b0;
  endtask

  // Offer one word until the DUT takes it, with random gaps
  task automatic send_word(word_t w, strb_t m, logic eot);
    logic taken;
    int   waited;
    taken  = 1'b0;
    waited = 0;
    while (!taken) begin
      @(posedge clk);
      bdi_i       <= w;
      bdi_valid_i <= ($urandom_range(0, 99) < gap_pct) ? '0 : m;
      bdi_eot_i   <= eot;
      @(negedge clk);
      taken = bdi_ready_o && (bdi_valid_i != '0);
      waited++;
      if (waited > TIMEOUT) fail_now("Timeout: bdi_ready_o never took the word");
    end
  endtask

  task automatic collect_digest(string name, word_t exp [HASH_WORDS]);
    int idx;
    int waited;
    idx    = 0;
    waited = 0;
    while (idx < HASH_WORDS) begin
      @(posedge clk);
      bdo_ready_i <= ($urandom_range(0, 99) >= stall_pct);
      @(negedge clk);
      check_bit({name, " done_o"}, 1'b0, done_o);
      check_bit({name, " bdo_eot_o"}, bdo_valid_o && (idx == HASH_WORDS - 1), bdo_eot_o);
      if (bdo_valid_o && bdo_ready_i) begin
        check_word($sformatf("%s word %0d", name, idx), exp[idx], bdo_o);
        idx++;
        waited = 0;
      end
      waited++;
      if (waited > TIMEOUT) fail_now("Timeout: digest word did not arrive");
    end
    @(posedge clk);
    bdo_ready_i <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!done_o) begin
      waited++;
      if (waited > TIMEOUT) fail_now("Timeout: done_o never pulsed");
      @(negedge clk);
    end
    check_bit({name, " bdo_valid_o at done"}, 1'b0, bdo_valid_o);
    @(negedge clk);
    check_bit({name, " done_o pulse end"}, 1'b0, done_o);
  endtask

  task automatic run_message(string name, int len);
    logic [7:0] msg [$];
    word_t      exp [HASH_WORDS];
    word_t      w;
    strb_t      m;
    int         nwords;
    msg = {};
    for (int i = 0; i < len; i++) msg.push_back(8'($urandom));
    expected_digest(msg, exp);
    start_message(len == 0);
    nwords = (len + BYTES_W - 1) / BYTES_W;
    for (int i = 0; i < nwords; i++) begin
      // Bytes past the message end carry junk
      w = {$urandom, $urandom};
      m = '0;
      for (int j = 0; j < BYTES_W && i * BYTES_W + j < len; j++) begin
        w[j*8 +: 8] = msg[i * BYTES_W + j];
        m[j] = 1'b1;
      end
      send_word(w, m, i == nwords - 1);
    end
    @(posedge clk);
    bdi_valid_i <= '0;
    bdi_eot_i   <= 1'b0;
    collect_digest(name, exp);
  endtask

  task automatic reset_mid_message();
    start_message(1'b0);
    send_word({$urandom, $urandom}, '1, 1'b0);
    send_word({$urandom, $urandom}, '1, 1'b0);
    @(posedge clk);
    rst         <= 1'b1;
    bdi_valid_i <= '0;
    finish_reset();
  endtask

  initial begin
    void'($urandom(32'h6699e8e7));
    clk         = 1'b0;
    rst         = 1'b1;
    start_i     = 1'b0;
    eoi_i       = 1'b0;
    bdi_i       = '0;
    bdi_valid_i = '0;
    bdi_eot_i   = 1'b0;
    bdo_ready_i = 1'b0;
    gap_pct     = 25;
    stall_pct   = 25;
    finish_reset();
    run_message("empty", 0);
    for (int r = 1; r < BYTES_W; r++) begin
      run_message($sformatf("partial_%0d", r), BYTES_W * $urandom_range(0, 3) + r);
    end
    // Full last word brings in the extra pad block
    for (int k = 1; k <= 4; k++) run_message($sformatf("full_%0d", k), BYTES_W * k);
    gap_pct   = 0;
    stall_pct = 0;
    run_message("no_stall", 29);
    gap_pct   = 75;
    stall_pct = 75;
    run_message("heavy_stall", 29);
    for (int n = 0; n < 12; n++) begin
      gap_pct   = $urandom_range(0, 80);
      stall_pct = $urandom_range(0, 80);
      run_message($sformatf("random_%0d", n), $urandom_range(0, 64));
    end
    reset_mid_message();
    run_message("after_reset", $urandom_range(1, 40));
    $display("** PASS **");
    $finish;
  end

endmodule

// File: ascon_hash_top.sv
`timescale 1ns/1ps

module ascon_hash_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_i,
  input  logic        eoi_i,
  input  logic [63:0] bdi_i,
  input  logic [7:0]  bdi_valid_i,
  input  logic        bdi_eot_i,
  input  logic        bdo_ready_i,
  output logic        bdi_ready_o,
  output logic [63:0] bdo_o,
  output logic        bdo_valid_o,
  output logic        bdo_eot_o,
  output logic        done_o
);

  // Padded block handed from input stage to controller
  logic        blk_valid;
  logic        blk_last;
  logic        blk_take;
  logic [63:0] blk;

  ascon_ctl_if ctl_if ();

  ascon_pad_stage pad_i (
    .clk         (clk),
    .rst         (rst),
    .bdi_i       (bdi_i),
    .bdi_valid_i (bdi_valid_i),
    .bdi_eot_i   (bdi_eot_i),
    .start_i     (start_i),
    .eoi_i       (eoi_i),
    .blk_take_i  (blk_take),
    .bdi_ready_o (bdi_ready_o),
    .blk_valid_o (blk_valid),
    .blk_last_o  (blk_last),
    .blk_o       (blk)
  );

  ascon_hash_fsm fsm_i (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .blk_valid_i (blk_valid),
    .blk_last_i  (blk_last),
    .blk_i       (blk),
    .bdo_ready_i (bdo_ready_i),
    .blk_take_o  (blk_take),
    .bdo_o       (bdo_o),
    .bdo_valid_o (bdo_valid_o),
    .bdo_eot_o   (bdo_eot_o),
    .done_o      (done_o),
    .ctl         (ctl_if.ctrl)
  );

  ascon_state state_i (
    .clk (clk),
    .rst (rst),
    .ctl (ctl_if.state)
  );

endmodule

// File: ascon_hash_fsm.sv
`timescale 1ns/1ps

module ascon_hash_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  logic                   blk_valid_i,
  input  logic                   blk_last_i,
  input  ascon_const_pkg::word_t blk_i,
  input  logic                   bdo_ready_i,
  output logic                   blk_take_o,
  output ascon_const_pkg::word_t bdo_o,
  output logic                   bdo_valid_o,
  output logic                   bdo_eot_o,
  output logic                   done_o,
  ascon_ctl_if.ctrl              ctl
);
  import ascon_const_pkg::*;
  import ascon_ctrl_pkg::*;

  fsm_t       fsm_q;
  fsm_t       fsm_d;
  round_idx_t rcnt_q;
  logic [1:0] wcnt_q;
  logic       done_q;
  logic       in_rounds;
  logic       rounds_done;
  logic       pad_next;
  logic       sqz_take;
  logic       sqz_last;

  function automatic word_t swap_bytes(word_t w);
    word_t res;
    for (int i = 0; i < BYTES_W; i++) begin
      res[i*8 +: 8] = w[(BYTES_W-1-i)*8 +: 8];
    end
    return res;
  endfunction

  assign in_rounds   = fsm_q inside {INIT, PRO_MSG, FINAL};
  assign rounds_done = in_rounds && (rcnt_q == '0);
  // Only the final pad-only block equals PAD_BLK with the last flag set
  assign pad_next    = blk_valid_i && blk_last_i && (blk_i == PAD_BLK);
  assign sqz_take    = (fsm_q == SQZ_HASH) && bdo_ready_i;
  assign sqz_last    = sqz_take && (wcnt_q == 2'(HASH_WORDS - 1));

  //////////////////////////////////////////////////////////////////////
  // Next state and opcode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fsm_d      = fsm_q;
    ctl.op     = OP_HOLD;
    blk_take_o = 1'b0;
    case (fsm_q)
      IDLE: begin
        if (start_i) begin
          ctl.op = OP_LOAD_IV;
          fsm_d  = INIT;
        end
      end
      INIT, PRO_MSG: begin
        ctl.op = OP_ROUND;
        if (rounds_done) fsm_d = pad_next ? PAD_MSG : ABS_MSG;
      end
      ABS_MSG: begin
        if (blk_valid_i) begin
          ctl.op     = OP_ABSORB;
          blk_take_o = 1'b1;
          fsm_d      = blk_last_i ? FINAL : PRO_MSG;
        end
      end
      PAD_MSG: begin
        ctl.op     = OP_ABSORB;
        blk_take_o = 1'b1;
        fsm_d      = FINAL;
      end
      FINAL: begin
        ctl.op = OP_ROUND;
        if (rounds_done) fsm_d = SQZ_HASH;
      end
      SQZ_HASH: begin
        // Hold the state while the sink stalls
        if (sqz_last) fsm_d = IDLE;
        else if (sqz_take) fsm_d = FINAL;
      end
      default: fsm_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_q  <= IDLE;
      rcnt_q <= round_idx_t'(ROUNDS_A - 1);
      wcnt_q <= '0;
      done_q <= 1'b0;
    end else begin
      fsm_q  <= fsm_d;
      done_q <= sqz_last;
      // Rounds left in the permutation, reloaded outside of it
      if (in_rounds && (rcnt_q != '0)) begin
        rcnt_q <= rcnt_q - 1'b1;
      end else begin
        rcnt_q <= round_idx_t'(ROUNDS_A - 1);
      end
      if (sqz_take) wcnt_q <= wcnt_q + 1'b1;
    end
  end

  assign ctl.round_idx = round_idx_t'(ROUNDS_A - 1) - rcnt_q;
  assign ctl.blk       = blk_i;

  // Digest words leave most significant byte first
  assign bdo_o       = swap_bytes(ctl.lane0);
  assign bdo_valid_o = fsm_q == SQZ_HASH;
  assign bdo_eot_o   = bdo_valid_o && (wcnt_q == 2'(HASH_WORDS - 1));
  assign done_o      = done_q;

  a_bdo_hold: assert property (@(posedge clk) disable iff (rst)
    bdo_valid_o && !bdo_ready_i |=> bdo_valid_o && $stable(bdo_o));

  // Each permutation lasts exactly ROUNDS_A cycles
  a_round_count: assert property (@(posedge clk) disable iff (rst)
    rounds_done |-> $past(in_rounds, ROUNDS_A - 1) && !$past(in_rounds, ROUNDS_A));

endmodule

// File: ascon_state.sv
`timescale 1ns/1ps

module ascon_state (
  input logic       clk,
  input logic       rst,
  ascon_ctl_if.state ctl
);
  import ascon_const_pkg::*;
  import ascon_ctrl_pkg::*;

  state_t s_q;
  state_t s_d;
  state_t s_rnd;

  ascon_round round_i (
    .s_i         (s_q),
    .round_idx_i (ctl.round_idx),
    .s_o         (s_rnd)
  );

  // Next state per opcode
  always_comb begin
    s_d = s_q;
    case (ctl.op)
      OP_LOAD_IV: begin
        s_d    = '0;
        s_d[0] = IV_HASH;
      end
      OP_ABSORB: s_d[0] = s_q[0] ^ ctl.blk;
      OP_ROUND:  s_d    = s_rnd;
      default:   s_d    = s_q;
    endcase
  end

  always_ff @(posedge clk) begin
    s_q <= s_d;
  end

  assign ctl.lane0 = s_q[0];

  // IV load and absorb always lead straight into a permutation
  a_update_then_round: assert property (@(posedge clk) disable iff (rst)
    (ctl.op == OP_LOAD_IV || ctl.op == OP_ABSORB) |=> ctl.op == OP_ROUND);

endmodule

// File: ascon_round.sv
`timescale 1ns/1ps

module ascon_round (
  input  ascon_const_pkg::state_t   s_i,
  input  ascon_ctrl_pkg::round_idx_t round_idx_i,
  output ascon_const_pkg::state_t   s_o
);
  import ascon_const_pkg::*;

  word_t a0, a1, a2, a3, a4;
  word_t t0, t1, t2, t3, t4;

  function automatic word_t ror(word_t x, int n);
    return (x >> n) | (x << (WORD_W - n));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Constant addition and substitution layer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    a0 = s_i[0];
    a1 = s_i[1];
    a2 = s_i[2] ^ word_t'(RC[round_idx_i]);
    a3 = s_i[3];
    a4 = s_i[4];
    // Bitsliced 5-bit S-box
    a0 = a0 ^ a4;
    a4 = a4 ^ a3;
    a2 = a2 ^ a1;
    t0 = ~a0 & a1;
    t1 = ~a1 & a2;
    t2 = ~a2 & a3;
    t3 = ~a3 & a4;
    t4 = ~a4 & a0;
    a0 = a0 ^ t1;
    a1 = a1 ^ t2;
    a2 = a2 ^ t3;
    a3 = a3 ^ t4;
    a4 = a4 ^ t0;
    a1 = a1 ^ a0;
    a0 = a0 ^ a4;
    a3 = a3 ^ a2;
    a2 = ~a2;
  end

  //////////////////////////////////////////////////////////////////////
  // Linear diffusion, one rotation pair per lane
  //////////////////////////////////////////////////////////////////////

  assign s_o[0] = a0 ^ ror(a0, 19) ^ ror(a0, 28);
  assign s_o[1] = a1 ^ ror(a1, 61) ^ ror(a1, 39);
  assign s_o[2] = a2 ^ ror(a2, 1) ^ ror(a2, 6);
  assign s_o[3] = a3 ^ ror(a3, 10) ^ ror(a3, 17);
  assign s_o[4] = a4 ^ ror(a4, 7) ^ ror(a4, 41);

endmodule

// File: ascon_pad_stage.sv
`timescale 1ns/1ps

module ascon_pad_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  ascon_const_pkg::word_t bdi_i,
  input  ascon_const_pkg::strb_t bdi_valid_i,
  input  logic                   bdi_eot_i,
  input  logic                   start_i,
  input  logic                   eoi_i,
  input  logic                   blk_take_i,
  output logic                   bdi_ready_o,
  output logic                   blk_valid_o,
  output logic                   blk_last_o,
  output ascon_const_pkg::word_t blk_o
);
  import ascon_const_pkg::*;

  logic  active_q;
  logic  full_q;
  logic  last_q;
  logic  pend_q;
  logic  accept;
  word_t blk_q;

  // Keep valid bytes, put 0x01 right above the last one
  function automatic word_t pad_word(word_t data, strb_t val);
    word_t res;
    res[7:0] = val[0] ? data[7:0] : 8'h00;
    for (int i = 1; i < BYTES_W; i++) begin
      res[i*8 +: 8] = val[i] ? data[i*8 +: 8] : (val[i-1] ? 8'h01 : 8'h00);
    end
    return res;
  endfunction

  assign bdi_ready_o = active_q && !full_q;
  assign accept      = bdi_ready_o && (bdi_valid_i != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= 1'b0;
      full_q   <= 1'b0;
      last_q   <= 1'b0;
      pend_q   <= 1'b0;
    end else if (start_i) begin
      // Empty message needs no bus words at all
      active_q <= !eoi_i;
      full_q   <= eoi_i;
      last_q   <= eoi_i;
      pend_q   <= 1'b0;
    end else if (accept) begin
      active_q <= !bdi_eot_i;
      full_q   <= 1'b1;
      last_q   <= bdi_eot_i && (bdi_valid_i != '1);
      pend_q   <= bdi_eot_i && (bdi_valid_i == '1);
    end else if (blk_take_i) begin
      // A full final word leaves the pad block behind it
      full_q   <= pend_q;
      last_q   <= pend_q;
      pend_q   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && eoi_i) begin
      blk_q <= PAD_BLK;
    end else if (accept) begin
      blk_q <= pad_word(bdi_i, bdi_valid_i);
    end else if (blk_take_i && pend_q) begin
      blk_q <= PAD_BLK;
    end
  end

  assign blk_valid_o = full_q;
  assign blk_last_o  = last_q;
  assign blk_o       = blk_q;

  // Controller only consumes a block that is actually held
  a_take_valid: assert property (@(posedge clk) disable iff (rst)
    blk_take_i |-> blk_valid_o);

endmodule

// File: ascon_ctl_if.sv
`timescale 1ns/1ps

interface ascon_ctl_if;
  import ascon_const_pkg::*;
  import ascon_ctrl_pkg::*;

  // Controller to state stage
  state_op_t  op;
  round_idx_t round_idx;
  word_t      blk;

  // Current x0, read back for the squeeze
  word_t      lane0;

  modport ctrl (
    output op,
    output round_idx,
    output blk,
    input  lane0
  );

  modport state (
    input  op,
    input  round_idx,
    input  blk,
    output lane0
  );

endinterface

// File: ascon_ctrl_pkg.sv
package ascon_ctrl_pkg;

  // Sponge controller states
  typedef enum logic [2:0] {
    IDLE,
    INIT,
    ABS_MSG,
    PRO_MSG,
    PAD_MSG,
    FINAL,
    SQZ_HASH
  } fsm_t;

  // What the state stage does on the next edge
  typedef enum logic [1:0] {
    OP_HOLD,
    OP_LOAD_IV,
    OP_ABSORB,
    OP_ROUND
  } state_op_t;

  // Index into the round constant table
  typedef logic [3:0] round_idx_t;

endpackage

// File: ascon_const_pkg.sv
package ascon_const_pkg;

  // Data path geometry
  localparam int WORD_W     = 64;
  localparam int BYTES_W    = 8;
  localparam int LANES      = 5;

  // Permutation and digest sizes
  localparam int ROUNDS_A   = 12;
  localparam int HASH_WORDS = 4;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [BYTES_W-1:0] strb_t;

  // Lane 0 is x0, lane 4 is x4
  typedef word_t [LANES-1:0] state_t;

  // Initial x0 for Ascon-Hash256, other lanes start at zero
  localparam word_t IV_HASH = 64'h0000080100cc0002;

  // Block that holds only the padding byte
  localparam word_t PAD_BLK = 64'h0000000000000001;

  // Round constants of Ascon-p[12], first round at index 0
  localparam logic [7:0] RC [ROUNDS_A] = '{
    8'hf0, 8'he1, 8'hd2, 8'hc3,
    8'hb4, 8'ha5, 8'h96, 8'h87,
    8'h78, 8'h69, 8'h5a, 8'h4b
  };

endpackage
